// File: warp_sched_top.f
verilog/warp_sched_pkg.sv
verilog/warp_ctl_decode.sv
verilog/warp_scheduler.sv
verilog/pending_instr.sv
verilog/warp_sched_top.sv
+incdir+sim
sim/warp_sched_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, then judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module warp_sched_tb \
    -f warp_sched_top.f -o warp_sched_sim \
    && ./obj_dir/warp_sched_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// File: sim/warp_sched_model.svh
// reference model of the scheduler, stepped once per rising edge
logic [warp_sched_pkg::NUM_WARPS-1:0]   m_active;
logic [warp_sched_pkg::NUM_WARPS-1:0]   m_waiting;
logic [warp_sched_pkg::NUM_THREADS-1:0] m_tmask [warp_sched_pkg::NUM_WARPS];
logic [warp_sched_pkg::PC_WIDTH-1:0]    m_pc [warp_sched_pkg::NUM_WARPS];
logic [warp_sched_pkg::NUM_WARPS-1:0]   m_bar [warp_sched_pkg::NUM_BARRIERS];
int                                     m_count [warp_sched_pkg::NUM_WARPS];
int                                     m_last;
logic                                   m_issue_valid;
warp_sched_pkg::issue_t                 m_issue;
logic                                   m_busy;
logic                                   m_ctl_error;
logic                                   m_dec_valid;
// the decode stage holds the raw command word
warp_sched_pkg::ctl_cmd_t               m_dec;

task automatic model_reset();
    for (int w = 0; w < warp_sched_pkg::NUM_WARPS; w++) begin
        m_tmask[w] = '0;
        m_pc[w]    = '0;
        m_count[w] = 0;
    end
    for (int b = 0; b < warp_sched_pkg::NUM_BARRIERS; b++) begin
        m_bar[b] = '0;
    end
    m_active      = 4'b0001;
    m_tmask[0]    = 4'b0001;
    m_pc[0]       = warp_sched_pkg::START_PC;
    m_waiting     = '0;
    m_last        = warp_sched_pkg::NUM_WARPS - 1;
    m_issue_valid = 1'b0;
    m_issue       = '0;
    m_busy        = 1'b0;
    m_ctl_error   = 1'b0;
    m_dec_valid   = 1'b0;
    m_dec         = '0;
endtask

task automatic model_step(input logic cv, input warp_sched_pkg::ctl_cmd_t cmd,
                          input logic cmv, input logic [1:0] cwid);
    logic [warp_sched_pkg::NUM_WARPS-1:0] ready;
    logic busy_next;
    logic inc;
    logic dec;
    int   inflight;
    int   sel;
    int   w;
    int   bar_id;
    busy_next = |m_active;
    for (int i = 0; i < warp_sched_pkg::NUM_WARPS; i++) begin
        busy_next = busy_next || (m_count[i] != 0);
        // the issue still in flight counts toward the limit
        inflight = (m_issue_valid && m_issue.wid == i[1:0]) ? 1 : 0;
        ready[i] = m_active[i] && !m_waiting[i]
                   && (m_count[i] + inflight < int'(warp_sched_pkg::PENDING_MAX));
    end
    sel = -1;
    for (int k = 1; k <= warp_sched_pkg::NUM_WARPS; k++) begin
        w = (m_last + k) % warp_sched_pkg::NUM_WARPS;
        if (sel < 0 && ready[w]) sel = w;
    end
    for (int i = 0; i < warp_sched_pkg::NUM_WARPS; i++) begin
        inc = m_issue_valid && m_issue.wid == i[1:0];
        dec = cmv && cwid == i[1:0] && m_count[i] > 0;
        if (inc && !dec && m_count[i] < int'(warp_sched_pkg::PENDING_MAX)) m_count[i]++;
        else if (dec && !inc) m_count[i]--;
    end
    m_issue_valid = (sel >= 0);
    if (sel >= 0) begin
        m_issue.wid   = sel[1:0];
        m_issue.tmask = m_tmask[sel];
        m_issue.pc    = m_pc[sel];
        m_pc[sel]     = m_pc[sel] + 32'd4;
        m_last        = sel;
    end
    if (m_dec_valid) begin
        case (m_dec.op)
            warp_sched_pkg::OP_TMC: begin
                m_active[m_dec.wid] = |m_dec.mask;
                m_tmask[m_dec.wid]  = m_dec.mask;
            end
            warp_sched_pkg::OP_WSPAWN: begin
                for (int i = 0; i < warp_sched_pkg::NUM_WARPS; i++) begin
                    if (m_dec.mask[i]) begin
                        m_active[i] = 1'b1;
                        m_tmask[i]  = 4'b0001;
                        m_pc[i]     = m_dec.arg;
                    end
                end
            end
            warp_sched_pkg::OP_BAR: begin
                bar_id = int'(m_dec.arg[0]);
                if ($countones(m_bar[bar_id]) == int'(m_dec.arg[2:1])) begin
                    m_waiting     = m_waiting & ~m_bar[bar_id];
                    m_bar[bar_id] = '0;
                end else begin
                    m_bar[bar_id][m_dec.wid] = 1'b1;
                    m_waiting[m_dec.wid]     = 1'b1;
                end
            end
            default: begin
                m_pc[m_dec.wid] = m_dec.arg;
            end
        endcase
    end
    m_ctl_error = cv && (cmd.op > 3'd3);
    m_dec_valid = cv && (cmd.op <= 3'd3);
    if (m_dec_valid) m_dec = cmd;
    m_busy = busy_next;
endtask

// true once nothing is active, in flight or outstanding
function automatic logic model_idle();
    logic idle;
    idle = !(|m_active) && !m_issue_valid;
    for (int i = 0; i < warp_sched_pkg::NUM_WARPS; i++) begin
        idle = idle && (m_count[i] == 0);
    end
    return idle;
endfunction

// File: sim/warp_sched_tb.sv
`timescale 1ns/1ps
`default_nettype none

module warp_sched_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int RAND_CYCLES     = 2800;
    localparam int DRAIN_CYCLES    = 60;
    localparam int WATCHDOG_CYCLES = 3000;

    logic                                 clk;
    logic                                 reset;
    logic                                 ctl_valid;
    warp_sched_pkg::ctl_cmd_t             ctl_cmd;
    logic                                 commit_valid;
    logic [warp_sched_pkg::WID_WIDTH-1:0] commit_wid;
    logic                                 issue_valid;
    warp_sched_pkg::issue_t               issue;
    logic [warp_sched_pkg::NUM_WARPS-1:0] active_warps;
    logic                                 ctl_error;
    logic                                 busy;

    int          errors;
    logic        checking;
    logic [31:0] rng_state;

    `include "warp_sched_model.svh"

    warp_sched_top warp_sched_top_i (
        .clk          (clk),
        .reset        (reset),
        .ctl_valid    (ctl_valid),
        .ctl_cmd      (ctl_cmd),
        .commit_valid (commit_valid),
        .commit_wid   (commit_wid),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .active_warps (active_warps),
        .ctl_error    (ctl_error),
        .busy         (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 8;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // about one opcode in eight is illegal
    function automatic warp_sched_pkg::ctl_cmd_t random_cmd();
        logic [31:0]              r;
        warp_sched_pkg::ctl_cmd_t c;
        r      = next_rand();
        c.op   = {r[2:0] == 3'd7, r[4:3]};
        c.wid  = r[6:5];
        c.mask = r[10:7];
        c.arg  = next_rand();
        return c;
    endfunction

    // step the model on the inputs sampled at the edge and drive the next ones
    task automatic step_clock(input logic send_cmd, input warp_sched_pkg::ctl_cmd_t cmd,
                              input logic allow_commit);
        int   start;
        int   pick;
        logic found;
        @(posedge clk);
        if (reset) model_reset();
        else model_step(ctl_valid, ctl_cmd, commit_valid, commit_wid);
        checking = 1'b1;
        found    = 1'b0;
        pick     = 0;
        start    = int'(next_rand() % 32'd4);
        for (int k = 0; k < warp_sched_pkg::NUM_WARPS; k++) begin
            if (!found && m_count[(start + k) % warp_sched_pkg::NUM_WARPS] != 0) begin
                found = 1'b1;
                pick  = (start + k) % warp_sched_pkg::NUM_WARPS;
            end
        end
        ctl_valid    <= send_cmd;
        ctl_cmd      <= cmd;
        commit_valid <= allow_commit && found;
        commit_wid   <= pick[1:0];
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            check_value("issue_valid", 64'(issue_valid), 64'(m_issue_valid));
            if (m_issue_valid) check_value("issue", 64'(issue), 64'(m_issue));
            check_value("active_warps", 64'(active_warps), 64'(m_active));
            check_value("ctl_error", 64'(ctl_error), 64'(m_ctl_error));
            check_value("busy", 64'(busy), 64'(m_busy));
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD + 2000);
        $display("watchdog expired before the test sequence completed");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0]              r;
        warp_sched_pkg::ctl_cmd_t cmd;
        int                       wait_cycles;
        errors       = 0;
        checking     = 1'b0;
        rng_state    = 32'd13;
        clk          = 1'b0;
        reset        = 1'b1;
        ctl_valid    = 1'b0;
        ctl_cmd      = '0;
        commit_valid = 1'b0;
        commit_wid   = '0;
        repeat (2) step_clock(1'b0, '0, 1'b0);
        reset <= 1'b0;
        // warp 0 alone without commits stalls at the limit
        repeat (10) step_clock(1'b0, '0, 1'b0);
        for (int c = 0; c < RAND_CYCLES; c++) begin
            r = next_rand();
            // commits withheld for one window in four
            step_clock(r[15:13] == 3'd0, random_cmd(), (r[5:4] != 2'd0) && ((c / 200) % 4 != 3));
        end
        // shut every warp down and drain the counters
        for (int w = 0; w < warp_sched_pkg::NUM_WARPS; w++) begin
            cmd     = '0;
            cmd.op  = warp_sched_pkg::OP_TMC;
            cmd.wid = w[1:0];
            step_clock(1'b1, cmd, 1'b1);
            step_clock(1'b0, '0, 1'b1);
        end
        wait_cycles = 0;
        while (!model_idle() && wait_cycles < DRAIN_CYCLES) begin
            step_clock(1'b0, '0, 1'b1);
            wait_cycles++;
        end
        if (!model_idle()) begin
            errors++;
            $display("warps and pending instructions did not drain in %0d cycles", DRAIN_CYCLES);
        end
        repeat (3) step_clock(1'b0, '0, 1'b0);
        @(negedge clk);
        check_value("busy after drain", 64'(busy), 64'd0);
        $display("closing report: %0d errors", errors);
        if (errors == 0) $display("TEST OK");
        else $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/warp_sched_top.sv
`timescale 1ns/1ps
`default_nettype none

module warp_sched_top (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  ctl_valid,
    input  wire warp_sched_pkg::ctl_cmd_t        ctl_cmd,
    input  wire                                  commit_valid,
    input  wire [warp_sched_pkg::WID_WIDTH-1:0]  commit_wid,
    output logic                                 issue_valid,
    output warp_sched_pkg::issue_t               issue,
    output logic [warp_sched_pkg::NUM_WARPS-1:0] active_warps,
    output logic                                 ctl_error,
    output logic                                 busy
);

    logic                                 dec_valid;
    warp_sched_pkg::warp_ctl_t            dec_ctl;
    logic [warp_sched_pkg::NUM_WARPS-1:0] pending_full;

    warp_ctl_decode warp_ctl_decode_i (
        .clk       (clk),
        .reset     (reset),
        .ctl_valid (ctl_valid),
        .ctl_cmd   (ctl_cmd),
        .dec_valid (dec_valid),
        .dec_ctl   (dec_ctl),
        .ctl_error (ctl_error)
    );

    warp_scheduler warp_scheduler_i (
        .clk          (clk),
        .reset        (reset),
        .dec_valid    (dec_valid),
        .dec_ctl      (dec_ctl),
        .pending_full (pending_full),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .active_warps (active_warps)
    );

    // issue stream feeds the outstanding counters
    pending_instr pending_instr_i (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_wid    (issue.wid),
        .commit_valid (commit_valid),
        .commit_wid   (commit_wid),
        .active_warps (active_warps),
        .pending_full (pending_full),
        .busy         (busy)
    );

endmodule

`default_nettype wire

// File: verilog/pending_instr.sv
`timescale 1ns/1ps
`default_nettype none

module pending_instr (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  issue_valid,
    input  wire [warp_sched_pkg::WID_WIDTH-1:0]  issue_wid,
    input  wire                                  commit_valid,
    input  wire [warp_sched_pkg::WID_WIDTH-1:0]  commit_wid,
    input  wire [warp_sched_pkg::NUM_WARPS-1:0]  active_warps,
    output logic [warp_sched_pkg::NUM_WARPS-1:0] pending_full,
    output logic                                 busy
);

    logic [warp_sched_pkg::NUM_WARPS-1:0][warp_sched_pkg::PCNT_WIDTH-1:0] counts;
    logic [warp_sched_pkg::NUM_WARPS-1:0] inc;
    logic [warp_sched_pkg::NUM_WARPS-1:0] dec;

    always_comb begin
        for (int i = 0; i < warp_sched_pkg::NUM_WARPS; i++) begin
            inc[i] = issue_valid && (issue_wid == i[warp_sched_pkg::WID_WIDTH-1:0]);
            // commits on an empty counter are dropped
            dec[i] = commit_valid && (commit_wid == i[warp_sched_pkg::WID_WIDTH-1:0])
                     && (counts[i] != '0);
            // also counts the issue still in flight
            pending_full[i] = (counts[i] == warp_sched_pkg::PENDING_MAX)
                              || ((counts[i] == warp_sched_pkg::PENDING_MAX - 1'b1)
                                  && inc[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < warp_sched_pkg::NUM_WARPS; i++) begin
                if (inc[i] && !dec[i]) begin
                    if (counts[i] != warp_sched_pkg::PENDING_MAX) begin
                        counts[i] <= counts[i] + 1'b1;
                    end
                end else if (dec[i] && !inc[i]) begin
                    counts[i] <= counts[i] - 1'b1;
                end
            end
        end
    end

    // one edge behind the state it reports
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else begin
            busy <= (|active_warps) || (|counts);
        end
    end

endmodule

`default_nettype wire

// File: verilog/warp_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module warp_scheduler (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  dec_valid,
    input  wire warp_sched_pkg::warp_ctl_t       dec_ctl,
    input  wire [warp_sched_pkg::NUM_WARPS-1:0]  pending_full,
    output logic                                 issue_valid,
    output warp_sched_pkg::issue_t               issue,
    output logic [warp_sched_pkg::NUM_WARPS-1:0] active_warps
);

    logic [warp_sched_pkg::NUM_WARPS-1:0] active_n;

    logic [warp_sched_pkg::NUM_WARPS-1:0][warp_sched_pkg::NUM_THREADS-1:0] tmasks;
    logic [warp_sched_pkg::NUM_WARPS-1:0][warp_sched_pkg::NUM_THREADS-1:0] tmasks_n;
    logic [warp_sched_pkg::NUM_WARPS-1:0][warp_sched_pkg::PC_WIDTH-1:0]    pcs;
    logic [warp_sched_pkg::NUM_WARPS-1:0][warp_sched_pkg::PC_WIDTH-1:0]    pcs_n;

    // one member mask per local barrier
    logic [warp_sched_pkg::NUM_BARRIERS-1:0][warp_sched_pkg::NUM_WARPS-1:0] bar_masks;
    logic [warp_sched_pkg::NUM_BARRIERS-1:0][warp_sched_pkg::NUM_WARPS-1:0] bar_masks_n;
    logic [warp_sched_pkg::NUM_WARPS-1:0] bar_stalls;
    logic [warp_sched_pkg::NUM_WARPS-1:0] bar_stalls_n;
    logic [warp_sched_pkg::WID_WIDTH:0]   bar_count;

    logic [warp_sched_pkg::NUM_WARPS-1:0] ready;
    logic [warp_sched_pkg::WID_WIDTH-1:0] last_wid;
    logic [warp_sched_pkg::WID_WIDTH-1:0] sel_wid;
    logic                                 sel_valid;

    assign ready = active_warps & ~bar_stalls & ~pending_full;

    // round robin, starting after the last issued warp
    always_comb begin
        logic [warp_sched_pkg::WID_WIDTH-1:0] idx;
        sel_valid = 1'b0;
        sel_wid   = last_wid;
        // walk from farthest to nearest so the nearest ready warp wins
        for (int k = warp_sched_pkg::NUM_WARPS; k >= 1; k--) begin
            idx = last_wid + k[warp_sched_pkg::WID_WIDTH-1:0];
            if (ready[idx]) begin
                sel_valid = 1'b1;
                sel_wid   = idx;
            end
        end
    end

    // warps already waiting on the addressed barrier
    always_comb begin
        bar_count = '0;
        for (int i = 0; i < warp_sched_pkg::NUM_WARPS; i++) begin
            bar_count = bar_count + {{warp_sched_pkg::WID_WIDTH{1'b0}},
                                     bar_masks[dec_ctl.bar_id][i]};
        end
    end

    always_comb begin
        active_n     = active_warps;
        tmasks_n     = tmasks;
        pcs_n        = pcs;
        bar_masks_n  = bar_masks;
        bar_stalls_n = bar_stalls;

        // advance pc of the issuing warp
        if (sel_valid) begin
            pcs_n[sel_wid] = pcs[sel_wid] + 32'd4;
        end

        // commands override the pc advance
        if (dec_valid) begin
            case (dec_ctl.op)
                warp_sched_pkg::OP_TMC: begin
                    active_n[dec_ctl.wid] = |dec_ctl.mask;
                    tmasks_n[dec_ctl.wid] = dec_ctl.mask;
                end
                warp_sched_pkg::OP_WSPAWN: begin
                    for (int i = 0; i < warp_sched_pkg::NUM_WARPS; i++) begin
                        if (dec_ctl.mask[i]) begin
                            active_n[i] = 1'b1;
                            tmasks_n[i] = {{(warp_sched_pkg::NUM_THREADS-1){1'b0}}, 1'b1};
                            pcs_n[i]    = dec_ctl.pc;
                        end
                    end
                end
                warp_sched_pkg::OP_BAR: begin
                    if (bar_count == {1'b0, dec_ctl.bar_size_m1}) begin
                        // last arrival releases everyone
                        bar_stalls_n &= ~bar_masks[dec_ctl.bar_id];
                        bar_masks_n[dec_ctl.bar_id] = '0;
                    end else begin
                        bar_masks_n[dec_ctl.bar_id][dec_ctl.wid] = 1'b1;
                        bar_stalls_n[dec_ctl.wid] = 1'b1;
                    end
                end
                warp_sched_pkg::OP_JUMP: begin
                    pcs_n[dec_ctl.wid] = dec_ctl.pc;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // only warp 0 alive out of reset
            active_warps <= {{(warp_sched_pkg::NUM_WARPS-1){1'b0}}, 1'b1};
            tmasks       <= '0;
            tmasks[0]    <= {{(warp_sched_pkg::NUM_THREADS-1){1'b0}}, 1'b1};
            pcs          <= '0;
            pcs[0]       <= warp_sched_pkg::START_PC;
            bar_masks    <= '0;
            bar_stalls   <= '0;
            // all ones so the first search starts at warp 0
            last_wid     <= '1;
            issue_valid  <= 1'b0;
        end else begin
            active_warps <= active_n;
            tmasks       <= tmasks_n;
            pcs          <= pcs_n;
            bar_masks    <= bar_masks_n;
            bar_stalls   <= bar_stalls_n;
            issue_valid  <= sel_valid;
            if (sel_valid) begin
                last_wid <= sel_wid;
            end
        end
    end

    // issue slot payload
    always_ff @(posedge clk) begin
        if (sel_valid) begin
            issue.wid   <= sel_wid;
            issue.tmask <= tmasks[sel_wid];
            issue.pc    <= pcs[sel_wid];
        end
    end

endmodule

`default_nettype wire

// File: verilog/warp_ctl_decode.sv
`timescale 1ns/1ps
`default_nettype none

module warp_ctl_decode (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       ctl_valid,
    input  wire warp_sched_pkg::ctl_cmd_t ctl_cmd,
    output logic                      dec_valid,
    output warp_sched_pkg::warp_ctl_t dec_ctl,
    output logic                      ctl_error
);

    logic                      legal;
    warp_sched_pkg::warp_ctl_t ctl_d;

    // field unpack by opcode
    always_comb begin
        legal             = 1'b1;
        ctl_d.op          = warp_sched_pkg::ctl_op_e'(ctl_cmd.op);
        ctl_d.wid         = ctl_cmd.wid;
        ctl_d.mask        = '0;
        ctl_d.pc          = '0;
        ctl_d.bar_id      = '0;
        ctl_d.bar_size_m1 = '0;
        case (ctl_cmd.op)
            warp_sched_pkg::OP_TMC: begin
                ctl_d.mask = ctl_cmd.mask;
            end
            warp_sched_pkg::OP_WSPAWN: begin
                // warp mask here, not a thread mask
                ctl_d.mask = ctl_cmd.mask;
                ctl_d.pc   = ctl_cmd.arg;
            end
            warp_sched_pkg::OP_BAR: begin
                ctl_d.bar_id      = ctl_cmd.arg[0];
                ctl_d.bar_size_m1 = ctl_cmd.arg[2:1];
            end
            warp_sched_pkg::OP_JUMP: begin
                ctl_d.pc = ctl_cmd.arg;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            ctl_error <= 1'b0;
        end else begin
            dec_valid <= ctl_valid && legal;
            ctl_error <= ctl_valid && !legal;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl_valid && legal) begin
            dec_ctl <= ctl_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/warp_sched_pkg.sv
`default_nettype none

package warp_sched_pkg;

    // core sizes
    localparam int NUM_WARPS    = 4;
    localparam int WID_WIDTH    = 2;
    localparam int NUM_THREADS  = 4;
    localparam int PC_WIDTH     = 32;
    localparam int NUM_BARRIERS = 2;

    localparam logic [PC_WIDTH-1:0] START_PC = 32'h0000_1000;

    // per-warp outstanding limit
    localparam int PCNT_WIDTH = 2;
    localparam logic [PCNT_WIDTH-1:0] PENDING_MAX = 2'd3;

    // control opcodes, 4 to 7 are illegal
    typedef enum logic [2:0] {
        OP_TMC    = 3'd0,
        OP_WSPAWN = 3'd1,
        OP_BAR    = 3'd2,
        OP_JUMP   = 3'd3
    } ctl_op_e;

    // raw command word as it arrives
    typedef struct packed {
        logic [2:0]             op;
        logic [WID_WIDTH-1:0]   wid;
        logic [NUM_THREADS-1:0] mask;
        logic [31:0]            arg;
    } ctl_cmd_t;

    typedef struct packed {
        ctl_op_e                         op;
        logic [WID_WIDTH-1:0]            wid;
        logic [NUM_THREADS-1:0]          mask;
        logic [PC_WIDTH-1:0]             pc;
        logic [$clog2(NUM_BARRIERS)-1:0] bar_id;
        logic [WID_WIDTH-1:0]            bar_size_m1;
    } warp_ctl_t;

    typedef struct packed {
        logic [WID_WIDTH-1:0]   wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [PC_WIDTH-1:0]    pc;
    } issue_t;

endpackage

`default_nettype wire
